// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = agc_loop_tb
FILELIST  = filelist.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
+incdir+rtl
rtl/agc_loop_pkg.sv
rtl/agc_calc_if.sv
rtl/agc_host_regs.sv
rtl/agc_sequencer.sv
rtl/agc_gain_update.sv
rtl/agc_loop_top.sv
tests/agc_stage_model.sv
tests/agc_loop_tb.sv

// ==== rtl/agc_calc_if.sv ====
`timescale 1ns/1ns

interface agc_calc_if import agc_loop_pkg::*; ();

    logic        req;          // Four-phase request, stats stable while high
    logic        ack;
    agc_stats_t  stats;
    logic [16:0] scale_step;   // Driven from the host register block
    logic [15:0] offset_step;
    logic [16:0] new_scale;
    logic [15:0] new_offset;

    modport seq (
        output req,
        output stats,
        input  ack,
        input  new_scale,
        input  new_offset
    );

    modport gain (
        input  req,
        input  stats,
        input  scale_step,
        input  offset_step,
        output ack,
        output new_scale,
        output new_offset
    );

endinterface

// ==== rtl/agc_gain_update.sv ====
`timescale 1ns/1ns
`include "agc_loop_cfg.svh"

module agc_gain_update (
    input  logic     aclk,
    input  logic     wb_rst_i,
    input  logic     agc_reset_i,
    agc_calc_if.gain calc
);

    localparam logic [16:0] SCALE_LO  = `AGC_SCALE_MIN + `AGC_SCALE_STEP;
    localparam logic [16:0] SCALE_HI  = `AGC_SCALE_MAX - `AGC_SCALE_STEP;
    localparam int          OFFSET_HI = int'(`AGC_OFFSET_LIMIT) - int'(`AGC_OFFSET_STEP);
    localparam int          OFFSET_LO = -OFFSET_HI;

    logic [24:0]        rms_adj;      // RMS figure after timescale reduction
    logic [16:0]        cur_scale;
    logic signed [15:0] cur_offset;
    logic [16:0]        scale_nxt;
    logic [15:0]        offset_nxt;
    logic               ack_q;
    logic [16:0]        new_scale_q;
    logic [15:0]        new_offset_q;

    assign rms_adj    = 25'(calc.stats[1] >> (17 - `AGC_TIMESCALE_BITS));
    assign cur_scale  = calc.stats[4][16:0];
    assign cur_offset = $signed(calc.stats[5][15:0]);

    // Scale moves one step against the RMS error, held inside the limits
    always_comb begin
        scale_nxt = cur_scale;
        if (rms_adj > `AGC_TARGET_RMS_SQ + `AGC_RMS_SQ_ERR) begin
            if (cur_scale > SCALE_LO) begin
                scale_nxt = cur_scale - calc.scale_step;
            end
        end else if (rms_adj < `AGC_TARGET_RMS_SQ - `AGC_RMS_SQ_ERR) begin
            if (cur_scale < SCALE_HI) begin
                scale_nxt = cur_scale + calc.scale_step;
            end
        end
    end

    // Offset balances the above and below counts
    always_comb begin
        offset_nxt = cur_offset;
        if ({1'b0, calc.stats[2]} > {1'b0, calc.stats[3]} + 33'(`AGC_OFFSET_ERR)) begin
            if (int'(cur_offset) > OFFSET_LO) begin
                offset_nxt = cur_offset - calc.offset_step;
            end
        end else if ({1'b0, calc.stats[3]} > {1'b0, calc.stats[2]} + 33'(`AGC_OFFSET_ERR)) begin
            if (int'(cur_offset) < OFFSET_HI) begin
                offset_nxt = cur_offset + calc.offset_step;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            ack_q <= 1'b0;
        end else if (calc.req && !ack_q) begin
            new_scale_q  <= scale_nxt;
            new_offset_q <= offset_nxt;
            ack_q        <= 1'b1;
        end else if (!calc.req && ack_q) begin
            ack_q <= 1'b0;        // Return to zero
        end
    end

    assign calc.ack        = ack_q;
    assign calc.new_scale  = new_scale_q;
    assign calc.new_offset = new_offset_q;

endmodule

// ==== rtl/agc_host_regs.sv ====
`timescale 1ns/1ns
`include "agc_loop_cfg.svh"

module agc_host_regs import agc_loop_pkg::*; (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  logic                  host_cyc_i,
    input  logic                  host_stb_i,
    input  logic                  host_we_i,
    input  logic [`AGC_ADR_W-1:0] host_adr_i,
    input  agc_stats_t            stats_i,
    output agc_word_t             host_dat_o,
    output logic                  host_ack_o,
    output logic [16:0]           scale_step_o,
    output logic [15:0]           offset_step_o
);

    host_state_e state_q;
    agc_word_t   resp_q;       // Readback word
    logic [16:0] scale_step_q;
    logic [15:0] offset_step_q;
    logic [3:0]  word_idx;

    assign word_idx = host_adr_i[5:2];

    //////////////////////////////
    // Host target FSM
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state_q       <= IDLE;
            scale_step_q  <= `AGC_SCALE_STEP;
            offset_step_q <= `AGC_OFFSET_STEP;
        end else begin
            case (state_q)
                IDLE: begin
                    if (host_cyc_i && host_stb_i) begin
                        state_q <= host_we_i ? WRITE : READ;
                    end
                end
                READ:    state_q <= ACK;
                WRITE:   state_q <= ACK;    // Steps are read-only for now
                default: state_q <= IDLE;
            endcase
        end
    end

    // Readback mux, address held by the master until ack
    always_ff @(posedge aclk) begin
        if (state_q == READ) begin
            if (host_adr_i[6]) begin
                case (word_idx)
                    4'd0:    resp_q <= {15'd0, scale_step_q};
                    4'd1:    resp_q <= {{16{offset_step_q[15]}}, offset_step_q};
                    default: resp_q <= '0;
                endcase
            end else if (word_idx < 4'(`AGC_NUM_STATS)) begin
                resp_q <= stats_i[word_idx];
            end else begin
                resp_q <= '0;
            end
        end
    end

    assign host_dat_o    = resp_q;
    assign host_ack_o    = (state_q == ACK);   // One-cycle ack
    assign scale_step_o  = scale_step_q;
    assign offset_step_o = offset_step_q;

endmodule

// ==== rtl/agc_loop_cfg.svh ====
`ifndef AGC_LOOP_CFG_SVH
`define AGC_LOOP_CFG_SVH

// Bus widths, shared by both buses
`define AGC_ADR_W            8
`define AGC_DAT_W            32

// Start point and loop steps
`define AGC_START_SCALE      17'd1500
`define AGC_START_OFFSET     16'd0
`define AGC_SCALE_STEP       17'd30
`define AGC_OFFSET_STEP      16'd25

// Loop targets and tolerances
`define AGC_TARGET_RMS_SQ    25'd16
`define AGC_RMS_SQ_ERR       25'd0
`define AGC_OFFSET_ERR       32'd5
`define AGC_TIMESCALE_BITS   4

// Limits on the applied values
`define AGC_SCALE_MIN        17'd64
`define AGC_SCALE_MAX        17'd16384
`define AGC_OFFSET_LIMIT     16'd1000
`define AGC_BOOT_CYCLES      5'd31

// AGC stage register map and control commands
`define AGC_ADR_CTRL         8'h00
`define AGC_ADR_SCALE        8'h10
`define AGC_ADR_OFFSET       8'h14
`define AGC_CMD_START        32'h0000_0001
`define AGC_CMD_RESET        32'h0000_0004
`define AGC_CMD_LOAD         32'h0000_0300
`define AGC_CMD_APPLY        32'h0000_0400
`define AGC_STATUS_DONE_BIT  1
`define AGC_NUM_STATS        6

`endif

// ==== rtl/agc_loop_pkg.sv ====
`include "agc_loop_cfg.svh"

package agc_loop_pkg;

    typedef logic [`AGC_DAT_W-1:0] agc_word_t;

    // Word 0 status, 1 RMS sq acc, 2 count above, 3 count below, 4 scale, 5 offset
    typedef agc_word_t [`AGC_NUM_STATS-1:0] agc_stats_t;

    // Control loop phases
    typedef enum logic [3:0] {
        BOOT,
        WRITE_SCALE,
        WRITE_OFFSET,
        LOAD,
        APPLY,
        RESET_AGC,
        START,
        POLL,
        READ_STATS,
        CALC
    } loop_state_e;

    typedef enum logic [1:0] {
        SEND,
        WAIT,
        PROCESS
    } bus_phase_e;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        WRITE,
        ACK
    } host_state_e;

    // Commands written to the AGC control register
    typedef enum logic [`AGC_DAT_W-1:0] {
        CMD_START = `AGC_CMD_START,
        CMD_RESET = `AGC_CMD_RESET,
        CMD_LOAD  = `AGC_CMD_LOAD,
        CMD_APPLY = `AGC_CMD_APPLY
    } agc_cmd_e;

endpackage

// ==== rtl/agc_loop_top.sv ====
`timescale 1ns/1ns
`include "agc_loop_cfg.svh"

module agc_loop_top import agc_loop_pkg::*; (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  logic                  agc_reset_i,
    // Host bus target
    input  logic                  host_cyc_i,
    input  logic                  host_stb_i,
    input  logic                  host_we_i,
    input  logic [`AGC_ADR_W-1:0] host_adr_i,
    output agc_word_t             host_dat_o,
    output logic                  host_ack_o,
    // AGC stage bus master
    output logic                  agc_cyc_o,
    output logic                  agc_stb_o,
    output logic                  agc_we_o,
    output logic [`AGC_ADR_W-1:0] agc_adr_o,
    output agc_word_t             agc_dat_o,
    input  agc_word_t             agc_dat_i,
    input  logic                  agc_ack_i
);

    agc_stats_t stats;

    agc_calc_if u_calc_if ();

    agc_host_regs u_agc_host_regs (
        .aclk          (aclk),
        .wb_rst_i      (wb_rst_i),
        .host_cyc_i    (host_cyc_i),
        .host_stb_i    (host_stb_i),
        .host_we_i     (host_we_i),
        .host_adr_i    (host_adr_i),
        .stats_i       (stats),
        .host_dat_o    (host_dat_o),
        .host_ack_o    (host_ack_o),
        .scale_step_o  (u_calc_if.scale_step),
        .offset_step_o (u_calc_if.offset_step)
    );

    agc_sequencer u_agc_sequencer (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst_i),
        .agc_reset_i (agc_reset_i),
        .agc_dat_i   (agc_dat_i),
        .agc_ack_i   (agc_ack_i),
        .agc_cyc_o   (agc_cyc_o),
        .agc_stb_o   (agc_stb_o),
        .agc_we_o    (agc_we_o),
        .agc_adr_o   (agc_adr_o),
        .agc_dat_o   (agc_dat_o),
        .stats_o     (stats),
        .calc        (u_calc_if.seq)
    );

    agc_gain_update u_agc_gain_update (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst_i),
        .agc_reset_i (agc_reset_i),
        .calc        (u_calc_if.gain)
    );

endmodule

// ==== rtl/agc_sequencer.sv ====
`timescale 1ns/1ns
`include "agc_loop_cfg.svh"

module agc_sequencer import agc_loop_pkg::*; (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  logic                  agc_reset_i,
    input  agc_word_t             agc_dat_i,
    input  logic                  agc_ack_i,
    output logic                  agc_cyc_o,
    output logic                  agc_stb_o,
    output logic                  agc_we_o,
    output logic [`AGC_ADR_W-1:0] agc_adr_o,
    output agc_word_t             agc_dat_o,
    output agc_stats_t            stats_o,
    agc_calc_if.seq               calc
);

    loop_state_e           state_q;
    bus_phase_e            phase_q;
    logic [4:0]            boot_cnt_q;
    logic [2:0]            stat_idx_q;
    logic [16:0]           scale_q;     // Values to write next
    logic [15:0]           offset_q;
    agc_stats_t            stats_q;
    agc_word_t             rdata_q;
    logic                  bus_act_q;   // Drives both cyc and stb
    logic                  we_q;
    logic [`AGC_ADR_W-1:0] adr_q;
    agc_word_t             dat_q;
    logic                  req_q;

    logic [`AGC_ADR_W-1:0] acc_adr;
    agc_word_t             acc_dat;
    logic                  acc_we;

    //////////////////////////////
    // Access for the current phase
    //////////////////////////////
    always_comb begin
        acc_adr = `AGC_ADR_CTRL;
        acc_dat = '0;
        acc_we  = 1'b1;
        case (state_q)
            WRITE_SCALE: begin
                acc_adr = `AGC_ADR_SCALE;
                acc_dat = {15'd0, scale_q};
            end
            WRITE_OFFSET: begin
                acc_adr = `AGC_ADR_OFFSET;
                acc_dat = {{16{offset_q[15]}}, offset_q};   // Signed offset
            end
            LOAD:      acc_dat = CMD_LOAD;
            APPLY:     acc_dat = CMD_APPLY;
            RESET_AGC: acc_dat = CMD_RESET;
            START:     acc_dat = CMD_START;
            POLL:      acc_we  = 1'b0;        // Status read
            READ_STATS: begin
                acc_adr = {{(`AGC_ADR_W-5){1'b0}}, stat_idx_q, 2'b00};
                acc_we  = 1'b0;
            end
            default: acc_we = 1'b0;
        endcase
    end

    //////////////////////////////
    // Control loop FSM
    //////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            state_q    <= BOOT;
            phase_q    <= SEND;
            boot_cnt_q <= `AGC_BOOT_CYCLES;
            stat_idx_q <= '0;
            scale_q    <= `AGC_START_SCALE;
            offset_q   <= `AGC_START_OFFSET;
            stats_q    <= '0;
            bus_act_q  <= 1'b0;
            we_q       <= 1'b0;
            req_q      <= 1'b0;
        end else begin
            case (state_q)
                BOOT: begin
                    if (boot_cnt_q != 5'd0) begin
                        boot_cnt_q <= boot_cnt_q - 5'd1;
                    end else begin
                        state_q <= WRITE_SCALE;
                    end
                end
                CALC: begin
                    // Four-phase handshake with the gain update block
                    case (phase_q)
                        SEND: begin
                            req_q   <= 1'b1;
                            phase_q <= WAIT;
                        end
                        WAIT: begin
                            if (calc.ack) begin
                                scale_q  <= calc.new_scale;
                                offset_q <= calc.new_offset;
                                req_q    <= 1'b0;
                                phase_q  <= PROCESS;
                            end
                        end
                        default: begin
                            if (!calc.ack) begin
                                state_q <= WRITE_SCALE;
                                phase_q <= SEND;
                            end
                        end
                    endcase
                end
                default: begin
                    // Bus master sub-machine, one access per pass
                    case (phase_q)
                        SEND: begin
                            bus_act_q <= 1'b1;
                            we_q      <= acc_we;
                            adr_q     <= acc_adr;
                            dat_q     <= acc_dat;
                            phase_q   <= WAIT;
                        end
                        WAIT: begin
                            if (agc_ack_i) begin
                                bus_act_q <= 1'b0;
                                we_q      <= 1'b0;
                                rdata_q   <= agc_dat_i;
                                phase_q   <= PROCESS;
                            end
                        end
                        default: begin
                            phase_q <= SEND;
                            case (state_q)
                                WRITE_SCALE:  state_q <= WRITE_OFFSET;
                                WRITE_OFFSET: state_q <= LOAD;
                                LOAD:         state_q <= APPLY;
                                APPLY: begin
                                    stats_q[4] <= {15'd0, scale_q};
                                    stats_q[5] <= {{16{offset_q[15]}}, offset_q};
                                    state_q    <= RESET_AGC;
                                end
                                RESET_AGC:    state_q <= START;
                                START:        state_q <= POLL;
                                POLL: begin
                                    // Not done yet, poll again
                                    if (rdata_q[`AGC_STATUS_DONE_BIT]) begin
                                        stat_idx_q <= '0;
                                        state_q    <= READ_STATS;
                                    end
                                end
                                READ_STATS: begin
                                    stats_q[stat_idx_q] <= rdata_q;
                                    if (stat_idx_q == 3'(`AGC_NUM_STATS - 1)) begin
                                        stat_idx_q <= '0;
                                        state_q    <= CALC;
                                    end else begin
                                        stat_idx_q <= stat_idx_q + 3'd1;
                                    end
                                end
                                default:      state_q <= BOOT;
                            endcase
                        end
                    endcase
                end
            endcase
        end
    end

    assign agc_cyc_o  = bus_act_q;
    assign agc_stb_o  = bus_act_q;
    assign agc_we_o   = we_q;
    assign agc_adr_o  = adr_q;
    assign agc_dat_o  = dat_q;
    assign stats_o    = stats_q;
    assign calc.stats = stats_q;
    assign calc.req   = req_q;

endmodule

// ==== tests/agc_loop_input.txt ====
// Columns (hex): polls status rms_sq_acc count_above count_below scale offset
//                expected_scale expected_offset
00 00000002 00028000 00000064 00000064 000005DC 00000000 000005BE 00000000
02 00000002 00014000 00000010 00000040 000005BE 00000000 000005DC 00000019
01 00000002 00020000 00000080 00000010 000005DC 00000019 000005DC 00000000
03 00000002 00028000 00000020 0000001B 0000005E 00000000 0000005E 00000000
00 00000002 00028000 00000200 00000000 0000005F FFFFFC31 00000041 FFFFFC31
01 00000002 00014000 00000000 00000100 00003FE2 000003CF 00003FE2 000003CF
02 00000002 00014000 00000003 00000030 00003FE1 000003CE 00003FFF 000003E7
00 00000002 00020000 00000090 00000008 00000400 FFFFFC32 00000400 FFFFFC19

// ==== tests/agc_loop_tb.sv ====
`timescale 1ns/1ns
`include "agc_loop_cfg.svh"

module agc_loop_tb import agc_loop_pkg::*; ();

    localparam int NUM_VEC     = 8;
    localparam int VEC_WORDS   = 9;
    localparam int HOST_AFTER  = 1;   // Host readback after this vector
    localparam int RESET_AFTER = 3;   // Loop reset pulse after this vector

    logic                  aclk;
    logic                  wb_rst_i;
    logic                  agc_reset_i;
    logic                  host_cyc;
    logic                  host_stb;
    logic                  host_we;
    logic [`AGC_ADR_W-1:0] host_adr;
    agc_word_t             host_dat;
    logic                  host_ack;
    logic                  agc_cyc;
    logic                  agc_stb;
    logic                  agc_we;
    logic [`AGC_ADR_W-1:0] agc_adr;
    agc_word_t             agc_dat_m;
    agc_word_t             agc_dat_s;
    logic                  agc_ack;
    logic                  hold;
    int                    cur_vec;
    int                    cur_polls;
    agc_stats_t            cur_stats;
    agc_word_t             vec_mem [NUM_VEC*VEC_WORDS];
    logic [40:0]           acc_q [$];   // {we, adr, data} per completed access
    int                    err_cnt;
    int                    chk_cnt;

    initial aclk = 1'b0;
    always #20 aclk = ~aclk;

    agc_loop_top u_agc_loop_top (
        .aclk        (aclk),
        .wb_rst_i    (wb_rst_i),
        .agc_reset_i (agc_reset_i),
        .host_cyc_i  (host_cyc),
        .host_stb_i  (host_stb),
        .host_we_i   (host_we),
        .host_adr_i  (host_adr),
        .host_dat_o  (host_dat),
        .host_ack_o  (host_ack),
        .agc_cyc_o   (agc_cyc),
        .agc_stb_o   (agc_stb),
        .agc_we_o    (agc_we),
        .agc_adr_o   (agc_adr),
        .agc_dat_o   (agc_dat_m),
        .agc_dat_i   (agc_dat_s),
        .agc_ack_i   (agc_ack)
    );

    agc_stage_model u_stage (
        .aclk     (aclk),
        .wb_rst_i (wb_rst_i),
        .cyc_i    (agc_cyc),
        .stb_i    (agc_stb),
        .we_i     (agc_we),
        .adr_i    (agc_adr),
        .dat_i    (agc_dat_m),
        .hold_i   (hold),
        .polls_i  (cur_polls),
        .stats_i  (cur_stats),
        .dat_o    (agc_dat_s),
        .ack_o    (agc_ack)
    );

    // Current vector as served by the stage model
    always @* begin
        cur_polls = int'(vec_mem[cur_vec*VEC_WORDS]);
        for (int k = 0; k < `AGC_NUM_STATS; k++) begin
            cur_stats[k] = vec_mem[cur_vec*VEC_WORDS+1+k];
        end
    end

    // Bus monitor
    always @(posedge aclk) begin
        if (!wb_rst_i) begin
            assert (agc_stb === agc_cyc) else begin
                err_cnt++;
                $display("AGC stage bus strobe does not follow cycle at %0t", $time);
            end
        end
        if (agc_cyc && agc_ack) begin
            acc_q.push_back({agc_we, agc_adr, agc_we ? agc_dat_m : agc_dat_s});
        end
    end

    //////////////////////////////
    // Checking helpers
    //////////////////////////////
    task automatic check_word(input string name, input agc_word_t exp, input agc_word_t act);
        chk_cnt++;
        assert (act === exp) else begin
            err_cnt++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic expect_access(input string name, input logic we,
                                 input logic [`AGC_ADR_W-1:0] adr,
                                 input agc_word_t dat, input logic check_dat);
        logic [40:0] e;
        while (acc_q.size() == 0) @(negedge aclk);
        e = acc_q.pop_front();
        check_word({name, " we"}, {31'd0, we}, {31'd0, e[40]});
        check_word({name, " adr"}, {24'd0, adr}, {24'd0, e[39:32]});
        if (check_dat) check_word({name, " data"}, dat, e[31:0]);
    endtask

    task automatic check_boot();
        expect_access("boot scale", 1'b1, `AGC_ADR_SCALE, 32'd1500, 1'b1);
        expect_access("boot offset", 1'b1, `AGC_ADR_OFFSET, 32'd0, 1'b1);
        expect_access("boot load", 1'b1, `AGC_ADR_CTRL, `AGC_CMD_LOAD, 1'b1);
        expect_access("boot apply", 1'b1, `AGC_ADR_CTRL, `AGC_CMD_APPLY, 1'b1);
    endtask

    task automatic check_iteration(input int v);
        int polls;
        polls = int'(vec_mem[v*VEC_WORDS]);
        expect_access("reset cmd", 1'b1, `AGC_ADR_CTRL, `AGC_CMD_RESET, 1'b1);
        expect_access("start cmd", 1'b1, `AGC_ADR_CTRL, `AGC_CMD_START, 1'b1);
        for (int p = 0; p <= polls; p++) begin
            expect_access("poll", 1'b0, `AGC_ADR_CTRL, '0, 1'b0);
        end
        for (int k = 0; k < `AGC_NUM_STATS; k++) begin
            expect_access("stats read", 1'b0, 8'(k*4), '0, 1'b0);
        end
        expect_access("scale write", 1'b1, `AGC_ADR_SCALE, vec_mem[v*VEC_WORDS+7], 1'b1);
        expect_access("offset write", 1'b1, `AGC_ADR_OFFSET, vec_mem[v*VEC_WORDS+8], 1'b1);
        expect_access("load cmd", 1'b1, `AGC_ADR_CTRL, `AGC_CMD_LOAD, 1'b1);
        expect_access("apply cmd", 1'b1, `AGC_ADR_CTRL, `AGC_CMD_APPLY, 1'b1);
    endtask

    // Ack must come two cycles after the request and last one cycle
    task automatic host_access(input string name, input logic we,
                               input logic [`AGC_ADR_W-1:0] adr, input agc_word_t exp);
        int   cyc_n;
        logic seen;
        @(negedge aclk);
        host_cyc = 1'b1;
        host_stb = 1'b1;
        host_we  = we;
        host_adr = adr;
        cyc_n    = 0;
        seen     = 1'b0;
        while (!seen && cyc_n < 8) begin
            @(negedge aclk);
            cyc_n++;
            seen = host_ack;
        end
        host_cyc = 1'b0;
        host_stb = 1'b0;
        host_we  = 1'b0;
        chk_cnt++;
        assert (seen) else begin
            err_cnt++;
            $display("Host access %s was never acknowledged", name);
        end
        check_word({name, " ack delay"}, 32'd2, 32'(cyc_n));
        if (seen && !we) check_word(name, exp, host_dat);
        @(negedge aclk);
        chk_cnt++;
        assert (!host_ack) else begin
            err_cnt++;
            $display("Host ack for %s stayed high past one cycle", name);
        end
    endtask

    task automatic host_checks(input int v);
        @(negedge aclk);
        hold = 1'b1;                          // Freeze the loop, stats stay put
        host_access("scale step", 1'b0, 8'h40, 32'd30);
        host_access("offset step", 1'b0, 8'h44, 32'd25);
        for (int k = 0; k < 4; k++) begin
            host_access("stats word", 1'b0, 8'(k*4), vec_mem[v*VEC_WORDS+1+k]);
        end
        host_access("stats scale", 1'b0, 8'h10, vec_mem[v*VEC_WORDS+7]);
        host_access("stats offset", 1'b0, 8'h14, vec_mem[v*VEC_WORDS+8]);
        host_access("step write", 1'b1, 8'h40, '0);
        host_access("scale step after write", 1'b0, 8'h40, 32'd30);
        hold = 1'b0;
    endtask

    task automatic pulse_loop_reset();
        repeat (6) @(negedge aclk);
        agc_reset_i = 1'b1;
        @(negedge aclk);
        agc_reset_i = 1'b0;
        @(negedge aclk);
        acc_q.delete();                       // Drop the interrupted iteration
        check_boot();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        wb_rst_i    = 1'b1;
        agc_reset_i = 1'b0;
        host_cyc    = 1'b0;
        host_stb    = 1'b0;
        host_we     = 1'b0;
        host_adr    = '0;
        hold        = 1'b0;
        cur_vec     = 0;
        err_cnt     = 0;
        chk_cnt     = 0;
        $readmemh("tests/agc_loop_input.txt", vec_mem);
        repeat (10) @(negedge aclk);
        wb_rst_i = 1'b0;
        check_boot();
        for (int v = 0; v < NUM_VEC; v++) begin
            check_iteration(v);
            if (v + 1 < NUM_VEC) cur_vec = v + 1;
            if (v == HOST_AFTER) host_checks(v);
            if (v == RESET_AFTER) pulse_loop_reset();
        end
        $display("Checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (NUM_VEC*2000) @(posedge aclk);
        $display("Watchdog expired after %0d cycles, the loop stalled", NUM_VEC*2000);
        $display("Checks %0d, errors %0d", chk_cnt, err_cnt + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tests/agc_stage_model.sv ====
`timescale 1ns/1ns
`include "agc_loop_cfg.svh"

module agc_stage_model import agc_loop_pkg::*; (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  logic [`AGC_ADR_W-1:0] adr_i,
    input  agc_word_t             dat_i,
    input  logic                  hold_i,      // Stalls the ack while high
    input  int                    polls_i,     // Not-done polls before done
    input  agc_stats_t            stats_i,
    output agc_word_t             dat_o,
    output logic                  ack_o
);

    logic busy;
    int   wait_cnt;
    int   poll_cnt;

    // Target side driven on the falling edge
    initial begin
        void'($urandom(9));
        ack_o <= 1'b0;
        dat_o <= '0;
        forever begin
            @(negedge aclk);
            if (wb_rst_i) begin
                ack_o    <= 1'b0;
                busy     <= 1'b0;
                wait_cnt <= 0;
                poll_cnt <= 0;
                dat_o    <= '0;
            end else if (ack_o) begin
                ack_o <= 1'b0;
                busy  <= 1'b0;
            end else if (!(cyc_i && stb_i)) begin
                busy <= 1'b0;                                   // Access abandoned
            end else if (!busy) begin
                busy     <= 1'b1;
                wait_cnt <= int'($urandom_range(3, 0));         // 1 to 4 cycles
            end else if (wait_cnt != 0) begin
                wait_cnt <= wait_cnt - 1;
            end else if (!hold_i) begin
                ack_o <= 1'b1;
                if (we_i) begin
                    if (adr_i == `AGC_ADR_CTRL && dat_i == `AGC_CMD_START) begin
                        poll_cnt <= 0;                          // New sample cycle
                    end
                end else if (adr_i == `AGC_ADR_CTRL) begin
                    dat_o    <= (poll_cnt < polls_i) ? '0 : stats_i[0];
                    poll_cnt <= poll_cnt + 1;
                end else begin
                    dat_o <= stats_i[adr_i[4:2]];
                end
            end
        end
    end

endmodule
